/* design/frame_store.sv */
`timescale 1ns/1ns

module frame_store import frame_uart_pkg::*; #(
  parameter int FRAME_PIXELS = 16,
  localparam int ADDR_W = (FRAME_PIXELS > 1) ? $clog2(FRAME_PIXELS) : 1,
  localparam int CNT_W = $clog2(FRAME_PIXELS + 1)
) (
  input  logic              clk,
  input  logic              uart_reset,
  // pixel write port
  input  logic              pix_valid,
  input  pixel_u            pix_data,
  output logic              pix_ready,
  // frame state
  input  logic              sending,
  input  logic              release_frame,
  output logic              frame_full,
  // read port for the sequencer
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output pixel_u            rd_data
);

  // pixel memory, raw bytes
  logic [PIXEL_BITS-1:0] mem [FRAME_PIXELS];

  // write pointer, one wider than the address so it can reach FRAME_PIXELS
  logic [CNT_W-1:0] wr_ptr;
  logic             wr_fire;

  //////////////////////////////////////////////////
  // fill state
  //////////////////////////////////////////////////

  // full once every slot has been written
  assign frame_full = (wr_ptr == CNT_W'(FRAME_PIXELS));

  // no loading while full or while the frame goes out
  assign pix_ready = !frame_full && !sending;

  assign wr_fire = pix_valid && pix_ready;

  // pointer restarts from zero once a frame has been sent
  always_ff @(posedge clk) begin
    if (uart_reset || release_frame) begin
      wr_ptr <= '0;
    end else if (wr_fire) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // arrival order from address 0
  // read data lands one cycle after rd_en and holds until the next read
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr[ADDR_W-1:0]] <= pix_data.raw;
    end
    if (rd_en) begin
      rd_data.raw <= mem[rd_addr];
    end
  end

endmodule

/* design/frame_uart_pkg.sv */
package frame_uart_pkg;

  //////////////////////////////////////////////////
  // pixel format
  //////////////////////////////////////////////////

  // rgb332 pixel
  localparam int PIXEL_BITS = 8;
  localparam int RED_BITS   = 3;
  localparam int GREEN_BITS = 3;
  localparam int BLUE_BITS  = 2;

  // one stored byte, seen raw or split into colour fields
  typedef union packed {
    logic [PIXEL_BITS-1:0] raw;
    struct packed {
      // red sits in the top bits
      logic [RED_BITS-1:0]   red;
      logic [GREEN_BITS-1:0] green;
      // blue in the bottom two
      logic [BLUE_BITS-1:0]  blue;
    } rgb;
  } pixel_u;

  //////////////////////////////////////////////////
  // serial framing
  //////////////////////////////////////////////////

  // 8n1 data payload
  localparam int UART_DATA_BITS  = 8;
  // start + data + stop
  localparam int UART_FRAME_BITS = 10;

  // red, green, blue bytes per pixel
  localparam int BYTES_PER_PIXEL = 3;

  // byte phase codes, sent in this order
  localparam logic [1:0] PHASE_RED   = 2'd0;
  localparam logic [1:0] PHASE_GREEN = 2'd1;
  localparam logic [1:0] PHASE_BLUE  = 2'd2;

endpackage

/* design/frame_uart_top.sv */
`timescale 1ns/1ns

module frame_uart_top import frame_uart_pkg::*; #(
  parameter int FRAME_PIXELS = 16,
  parameter int CLKS_PER_BIT = 4,
  localparam int ADDR_W = (FRAME_PIXELS > 1) ? $clog2(FRAME_PIXELS) : 1,
  localparam int CNT_W = $clog2(FRAME_PIXELS + 1)
) (
  input  logic             clk,
  input  logic             uart_reset,
  // pixel load port
  input  logic             pix_valid,
  input  pixel_u           pix_data,
  output logic             pix_ready,
  // transfer control
  input  logic             start,
  output logic             txd,
  output logic             busy,
  output logic             frame_done,
  output logic [CNT_W-1:0] pixels_sent
);

  // store to sequencer
  logic                      frame_full;
  logic                      rd_en;
  logic [ADDR_W-1:0]         rd_addr;
  pixel_u                    rd_data;
  // sequencer to serializer
  logic                      byte_valid;
  logic [UART_DATA_BITS-1:0] byte_data;
  logic                      byte_ready;

  //////////////////////////////////////////////////
  // frame memory
  //////////////////////////////////////////////////

  // busy blocks loading, frame_done frees the store
  frame_store #(
    .FRAME_PIXELS (FRAME_PIXELS)
  ) i_frame_store (
    .clk           (clk),
    .uart_reset    (uart_reset),
    .pix_valid     (pix_valid),
    .pix_data      (pix_data),
    .pix_ready     (pix_ready),
    .sending       (busy),
    .release_frame (frame_done),
    .frame_full    (frame_full),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  //////////////////////////////////////////////////
  // pixel to rgb bytes
  //////////////////////////////////////////////////

  pixel_byte_sequencer #(
    .FRAME_PIXELS (FRAME_PIXELS)
  ) i_pixel_byte_sequencer (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .start       (start),
    .frame_full  (frame_full),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .byte_ready  (byte_ready),
    .busy        (busy),
    .frame_done  (frame_done),
    .pixels_sent (pixels_sent)
  );

  //////////////////////////////////////////////////
  // serial line
  //////////////////////////////////////////////////

  uart_serializer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_serializer (
    .clk        (clk),
    .uart_reset (uart_reset),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_ready (byte_ready),
    .txd        (txd)
  );

endmodule

/* design/pixel_byte_sequencer.sv */
`timescale 1ns/1ns

module pixel_byte_sequencer import frame_uart_pkg::*; #(
  parameter int FRAME_PIXELS = 16,
  localparam int ADDR_W = (FRAME_PIXELS > 1) ? $clog2(FRAME_PIXELS) : 1,
  localparam int CNT_W = $clog2(FRAME_PIXELS + 1)
) (
  input  logic                      clk,
  input  logic                      uart_reset,
  input  logic                      start,
  input  logic                      frame_full,
  // store read port
  output logic                      rd_en,
  output logic [ADDR_W-1:0]         rd_addr,
  input  pixel_u                    rd_data,
  // byte stream to the serializer
  output logic                      byte_valid,
  output logic [UART_DATA_BITS-1:0] byte_data,
  input  logic                      byte_ready,
  // status
  output logic                      busy,
  output logic                      frame_done,
  output logic [CNT_W-1:0]          pixels_sent
);

  logic [CNT_W-1:0] rd_cnt;
  logic             all_issued;
  // store read register holds a prefetched pixel
  logic             pf_valid;
  logic             pf_take;
  // pixel on the byte port
  pixel_u           cur;
  logic             cur_valid;
  logic [1:0]       phase;
  logic             byte_accept;
  logic             last_byte;
  logic             last_pixel;
  // last blue byte handed over, waiting for the line to go idle
  logic             draining;
  logic             start_ok;

  assign start_ok    = start && frame_full && !busy;
  assign all_issued  = (rd_cnt == CNT_W'(FRAME_PIXELS));
  assign rd_addr     = rd_cnt[ADDR_W-1:0];
  assign byte_valid  = cur_valid;
  assign byte_accept = byte_valid && byte_ready;
  assign last_byte   = (phase == 2'(BYTES_PER_PIXEL - 1));
  assign last_pixel  = (pixels_sent == CNT_W'(FRAME_PIXELS - 1));

  // move prefetch into the byte stage when it is empty or its blue byte leaves
  assign pf_take = pf_valid && (!cur_valid || (byte_accept && last_byte));
  // refill the read register as soon as it is free or being emptied
  assign rd_en = busy && !all_issued && (!pf_valid || pf_take);

  //////////////////////////////////////////////////
  // byte encoding
  //////////////////////////////////////////////////

  // colour field left-aligned, zeros below
  always_comb begin
    case (phase)
      PHASE_RED:   byte_data = {cur.rgb.red, {(UART_DATA_BITS - RED_BITS){1'b0}}};
      PHASE_GREEN: byte_data = {cur.rgb.green, {(UART_DATA_BITS - GREEN_BITS){1'b0}}};
      PHASE_BLUE:  byte_data = {cur.rgb.blue, {(UART_DATA_BITS - BLUE_BITS){1'b0}}};
      default:     byte_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // frame walk
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      busy        <= 1'b0;
      draining    <= 1'b0;
      frame_done  <= 1'b0;
      rd_cnt      <= '0;
      pf_valid    <= 1'b0;
      cur_valid   <= 1'b0;
      phase       <= PHASE_RED;
      pixels_sent <= '0;
    end else begin
      frame_done <= 1'b0;
      if (start_ok) begin
        busy        <= 1'b1;
        rd_cnt      <= '0;
        pixels_sent <= '0;
        phase       <= PHASE_RED;
        pf_valid    <= 1'b0;
        cur_valid   <= 1'b0;
      end else if (draining) begin
        // byte_ready back high means the stop bit is out
        if (byte_ready) begin
          draining   <= 1'b0;
          busy       <= 1'b0;
          frame_done <= 1'b1;
        end
      end else begin
        if (rd_en) begin
          rd_cnt <= rd_cnt + 1'b1;
        end
        // read data valid from the cycle after rd_en
        if (rd_en) begin
          pf_valid <= 1'b1;
        end else if (pf_take) begin
          pf_valid <= 1'b0;
        end
        // red, green, blue then wrap
        if (byte_accept) begin
          if (last_byte) begin
            phase       <= PHASE_RED;
            pixels_sent <= pixels_sent + 1'b1;
            draining    <= last_pixel;
          end else begin
            phase <= phase + 2'd1;
          end
        end
        if (pf_take) begin
          cur_valid <= 1'b1;
        end else if (byte_accept && last_byte) begin
          cur_valid <= 1'b0;
        end
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk) begin
    if (pf_take) begin
      cur <= rd_data;
    end
  end

endmodule

/* design/uart_serializer.sv */
`timescale 1ns/1ns

module uart_serializer import frame_uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic                      clk,
  input  logic                      uart_reset,
  input  logic                      byte_valid,
  input  logic [UART_DATA_BITS-1:0] byte_data,
  output logic                      byte_ready,
  output logic                      txd
);

  localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W  = $clog2(UART_FRAME_BITS);

  // stop, data, start with the start bit at the bottom
  logic [UART_FRAME_BITS-1:0] shift_q;
  // cycles within the current bit
  logic [BAUD_W-1:0]          baud_cnt;
  // which bit of the frame is on the line
  logic [BIT_W-1:0]           bit_cnt;
  logic                       active;
  logic                       accept;
  logic                       bit_end;
  logic                       frame_end;

  assign accept    = byte_valid && byte_ready;
  assign bit_end   = active && (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
  assign frame_end = bit_end && (bit_cnt == BIT_W'(UART_FRAME_BITS - 1));

  //////////////////////////////////////////////////
  // bit timing and shift
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      // all ones keeps the line idle high
      shift_q  <= '1;
    end else if (accept) begin
      // start bit goes out on this edge
      active   <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shift_q  <= {1'b1, byte_data, 1'b0};
    end else if (frame_end) begin
      // stop bit done, back to idle
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shift_q  <= '1;
    end else if (bit_end) begin
      // next bit, lsb first, ones fill from the top
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
      shift_q  <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
    end else if (active) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // only take a byte when the line is idle
  assign byte_ready = !active;

  // line follows the bottom of the shift register
  assign txd = shift_q[0];

endmodule

/* list.f */
design/frame_uart_pkg.sv
design/frame_store.sv
design/pixel_byte_sequencer.sv
design/uart_serializer.sv
design/frame_uart_top.sv
verification/frame_uart_props.sv
verification/frame_uart_tb.sv

/* verification/frame_uart_props.sv */
`timescale 1ns/1ns

module frame_uart_props import frame_uart_pkg::*; (
  input logic                      clk,
  input logic                      uart_reset,
  input logic                      byte_valid,
  input logic [UART_DATA_BITS-1:0] byte_data,
  input logic                      byte_ready,
  input logic                      txd,
  input logic                      frame_done
);

  // assertion failures so far
  int assert_failures = 0;

  //////////////////////////////////////////////////
  // serial line
  //////////////////////////////////////////////////

  // serializer idle means the line sits high
  idle_line_high: assert property (
    @(posedge clk) disable iff (uart_reset) byte_ready |-> txd
  ) else begin
    $error("txd low while the serializer is idle");
    assert_failures++;
  end

  //////////////////////////////////////////////////
  // byte handshake and frame end
  //////////////////////////////////////////////////

  // stalled byte keeps its value until taken
  byte_held: assert property (
    @(posedge clk) disable iff (uart_reset)
    (byte_valid && !byte_ready) |=> (byte_valid && $stable(byte_data))
  ) else begin
    $error("byte changed or dropped while stalled");
    assert_failures++;
  end

  // end of frame is a one cycle pulse
  done_single_cycle: assert property (
    @(posedge clk) disable iff (uart_reset) frame_done |=> !frame_done
  ) else begin
    $error("frame_done held longer than one cycle");
    assert_failures++;
  end

endmodule

// sequencer to serializer signals as seen at the top level
bind frame_uart_top frame_uart_props i_frame_uart_props (
  .clk        (clk),
  .uart_reset (uart_reset),
  .byte_valid (byte_valid),
  .byte_data  (byte_data),
  .byte_ready (byte_ready),
  .txd        (txd),
  .frame_done (frame_done)
);

/* verification/frame_uart_tb.sv */
`timescale 1ns/1ns

module frame_uart_tb import frame_uart_pkg::*; ();

  localparam int FRAME_PIXELS = 16;
  localparam int CLKS_PER_BIT = 4;
  localparam int CNT_W        = $clog2(FRAME_PIXELS + 1);
  // cycles allowed for a start bit or for frame_done
  localparam int BYTE_WAIT    = 100;
  localparam int DONE_WAIT    = 200;

  logic             clk;
  logic             uart_reset;
  logic             pix_valid;
  pixel_u           pix_data;
  logic             pix_ready;
  logic             start;
  logic             txd;
  logic             busy;
  logic             frame_done;
  logic [CNT_W-1:0] pixels_sent;

  // pixels the store should hold, in address order
  pixel_u expected[$];
  int     seed = 83;
  int     errors;
  int     errors_at_start;
  int     tests_run;
  int     tests_failed;

  frame_uart_top #(
    .FRAME_PIXELS (FRAME_PIXELS),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_frame_uart_top (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .pix_ready   (pix_ready),
    .start       (start),
    .txd         (txd),
    .busy        (busy),
    .frame_done  (frame_done),
    .pixels_sent (pixels_sent)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    uart_reset = 1'b1;
    repeat (3) step();
    uart_reset = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    step();
    start = 1'b0;
  endtask

  // offer one pixel, give up after max_wait cycles without pix_ready
  task automatic load_pixel(input pixel_u p, input int max_wait, output bit accepted);
    int n;
    accepted  = 1'b0;
    pix_valid = 1'b1;
    pix_data  = p;
    for (n = 0; n < max_wait && !accepted; n++) begin
      // ready seen now means the handshake lands on the coming edge
      if (pix_ready) accepted = 1'b1;
      step();
    end
    pix_valid = 1'b0;
  endtask

  // fixed pattern from the address, or random bytes
  task automatic load_pixels(input int count, input bit use_random);
    pixel_u p;
    bit     acc;
    int     i;
    for (i = 0; i < count; i++) begin
      if (use_random) p.raw = 8'($random(seed));
      else p.raw = 8'(expected.size() * 37 + 11);
      load_pixel(p, 20, acc);
      if (acc) begin
        expected.push_back(p);
      end else begin
        $display("pixel write at index %0d was never accepted", expected.size());
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // serial receiver model
  //////////////////////////////////////////////////

  // finds the start bit, then samples each bit at its middle
  task automatic recv_byte(output logic [UART_DATA_BITS-1:0] data, output bit ok);
    int n;
    int i;
    ok   = 1'b0;
    data = '0;
    for (n = 0; n < BYTE_WAIT && txd; n++) step();
    if (txd) begin
      $display("timeout waiting for a start bit on txd");
      errors++;
      return;
    end
    repeat (CLKS_PER_BIT / 2) step();
    if (txd) begin
      $display("start bit on txd was shorter than half a bit");
      errors++;
      return;
    end
    // lsb first
    for (i = 0; i < UART_DATA_BITS; i++) begin
      repeat (CLKS_PER_BIT) step();
      data[i] = txd;
    end
    repeat (CLKS_PER_BIT) step();
    if (!txd) begin
      $display("stop bit on txd was low");
      errors++;
      return;
    end
    ok = 1'b1;
  endtask

  // a window longer than one uart frame with no activity allowed
  task automatic watch_idle(output bit busy_seen, output bit line_low);
    int n;
    busy_seen = 1'b0;
    line_low  = 1'b0;
    for (n = 0; n < UART_FRAME_BITS * CLKS_PER_BIT + 8; n++) begin
      if (busy) busy_seen = 1'b1;
      if (!txd) line_low = 1'b1;
      step();
    end
  endtask

  task automatic wait_frame_done(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < DONE_WAIT && !seen; n++) begin
      if (frame_done) seen = 1'b1;
      else step();
    end
    if (!seen) begin
      $display("timeout waiting for frame_done");
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_pixel(input string name, input pixel_u exp, input pixel_u act);
    if (act !== exp) begin
      $display("FAILED %s: pixel expected %h, actual %h", name, exp.raw, act.raw);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: pixels_sent expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("FAILED %s: %s expected %b, actual %b", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_at_start);
    end else begin
      $display("%s: ok", name);
    end
    errors_at_start = errors;
  endtask

  // start, then three bytes per stored pixel rebuilt in address order
  task automatic send_and_check(input string name);
    logic [UART_DATA_BITS-1:0] r;
    logic [UART_DATA_BITS-1:0] g;
    logic [UART_DATA_BITS-1:0] b;
    pixel_u                    got;
    bit                        ok;
    int                        i;
    pulse_start();
    for (i = 0; i < expected.size(); i++) begin
      recv_byte(r, ok);
      if (ok) recv_byte(g, ok);
      if (ok) recv_byte(b, ok);
      if (!ok) break;
      // fields left aligned, zeros below
      check_flag(name, "red padding", 1'b1, r[UART_DATA_BITS-RED_BITS-1:0] == '0);
      check_flag(name, "green padding", 1'b1, g[UART_DATA_BITS-GREEN_BITS-1:0] == '0);
      check_flag(name, "blue padding", 1'b1, b[UART_DATA_BITS-BLUE_BITS-1:0] == '0);
      got.rgb.red   = r[UART_DATA_BITS-1 -: RED_BITS];
      got.rgb.green = g[UART_DATA_BITS-1 -: GREEN_BITS];
      got.rgb.blue  = b[UART_DATA_BITS-1 -: BLUE_BITS];
      check_pixel(name, expected[i], got);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_state();
    check_flag("reset_state", "txd", 1'b1, txd);
    check_flag("reset_state", "busy", 1'b0, busy);
    check_flag("reset_state", "frame_done", 1'b0, frame_done);
    check_flag("reset_state", "pix_ready", 1'b1, pix_ready);
    check_count("reset_state", '0, pixels_sent);
    end_test("reset_state");
  endtask

  task automatic start_ignored_partial();
    bit busy_seen;
    bit line_low;
    load_pixels(5, 1'b0);
    pulse_start();
    watch_idle(busy_seen, line_low);
    check_flag("start_ignored_partial", "busy seen", 1'b0, busy_seen);
    check_flag("start_ignored_partial", "txd low seen", 1'b0, line_low);
    end_test("start_ignored_partial");
  endtask

  // tops up the partial frame from the previous test
  task automatic store_fills();
    pixel_u extra;
    bit     acc;
    load_pixels(FRAME_PIXELS - expected.size(), 1'b0);
    check_flag("store_fills", "pix_ready when full", 1'b0, pix_ready);
    extra.raw = 8'hff;
    load_pixel(extra, 5, acc);
    check_flag("store_fills", "extra pixel accepted", 1'b0, acc);
    end_test("store_fills");
  endtask

  task automatic frame_sent();
    send_and_check("frame_sent");
    end_test("frame_sent");
  endtask

  task automatic end_of_frame();
    bit seen;
    bit extra_pulse;
    int n;
    extra_pulse = 1'b0;
    wait_frame_done(seen);
    if (seen) begin
      check_flag("end_of_frame", "busy at frame_done", 1'b0, busy);
      check_count("end_of_frame", CNT_W'(FRAME_PIXELS), pixels_sent);
      step();
      // store pointer clears one cycle after the pulse
      check_flag("end_of_frame", "pix_ready", 1'b1, pix_ready);
      for (n = 0; n < 20; n++) begin
        if (frame_done) extra_pulse = 1'b1;
        step();
      end
      check_flag("end_of_frame", "second frame_done pulse", 1'b0, extra_pulse);
      check_count("end_of_frame", CNT_W'(FRAME_PIXELS), pixels_sent);
    end
    end_test("end_of_frame");
  endtask

  task automatic second_frame_and_reset();
    bit seen;
    bit busy_seen;
    bit line_low;
    expected.delete();
    load_pixels(FRAME_PIXELS, 1'b1);
    send_and_check("second_frame_and_reset");
    wait_frame_done(seen);
    step();
    // reset with the store partly loaded
    expected.delete();
    load_pixels(6, 1'b1);
    apply_reset();
    check_flag("second_frame_and_reset", "pix_ready after reset", 1'b1, pix_ready);
    check_count("second_frame_and_reset", '0, pixels_sent);
    // six more than this would fill the store only if reset had not cleared it
    expected.delete();
    load_pixels(FRAME_PIXELS - 6, 1'b1);
    pulse_start();
    watch_idle(busy_seen, line_low);
    check_flag("second_frame_and_reset", "busy seen", 1'b0, busy_seen);
    check_flag("second_frame_and_reset", "txd low seen", 1'b0, line_low);
    end_test("second_frame_and_reset");
  endtask

  initial begin
    pix_valid       = 1'b0;
    pix_data        = '0;
    start           = 1'b0;
    errors          = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    apply_reset();
    reset_state();
    start_ignored_partial();
    store_fills();
    frame_sent();
    end_of_frame();
    second_frame_and_reset();
    // add bound assertion failures
    errors = errors + i_frame_uart_top.i_frame_uart_props.assert_failures;
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
